/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Geometry
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 4;

    // Address fields, low to high: byte, word in line, set index, tag
    localparam int BYTE_OFFSET_WIDTH = $clog2(BYTES_PER_WORD);
    localparam int OFFSET_WIDTH = $clog2(WORDS_PER_LINE);
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_OFFSET_WIDTH;
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - BYTE_OFFSET_WIDTH;
    localparam int WAY_WIDTH = $clog2(NUM_WAYS);

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [BYTES_PER_WORD-1:0] byteen_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [WAY_WIDTH-1:0] way_t;

    // Tag and index together name one line in memory
    typedef logic [TAG_WIDTH+INDEX_WIDTH-1:0] line_addr_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      line;
    } evict_t;

endpackage

`default_nettype wire

/* design/dcache_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Word-wide memory bus, one word per ack
interface mem_bus_if;
    logic                                   req;
    logic                                   we;
    logic [dcache_pkg::WORD_ADDR_WIDTH-1:0] addr;
    dcache_pkg::word_t                      wdata;
    logic                                   ack;
    dcache_pkg::word_t                      rdata;

    modport master (output req, we, addr, wdata, input ack, rdata);
    modport slave (input req, we, addr, wdata, output ack, rdata);
endinterface

// Line fetch request from the core to the refill engine
interface refill_if;
    logic                   start;
    dcache_pkg::line_addr_t line_addr;
    logic                   done;
    dcache_pkg::line_t      line;

    modport core (output start, line_addr, input done, line);
    modport engine (input start, line_addr, output done, line);
endinterface

`default_nettype wire

/* design/cache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
    parameter type entry_t = logic
) (
    input  logic               clk,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  entry_t             wdata,
    input  dcache_pkg::index_t raddr,
    output entry_t             rdata
);

    entry_t mem [dcache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Write-first: a same-set read sees the new entry
        if (we && waddr == raddr) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* design/dcache_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_read,
    input  logic                              cpu_write,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr,
    input  dcache_pkg::word_t                 cpu_wdata,
    input  dcache_pkg::byteen_t               cpu_byteen,
    output logic                              cpu_stall,
    output dcache_pkg::word_t                 cpu_rdata,
    output logic                              cpu_rvalid,
    refill_if.core                            refill,
    output logic                              wb_push,
    output dcache_pkg::evict_t                wb_evict,
    input  logic                              wb_busy
);

    localparam int IDX_LSB = dcache_pkg::BYTE_OFFSET_WIDTH + dcache_pkg::OFFSET_WIDTH;

    typedef enum logic [2:0] {SWEEP, IDLE, PUSH, START, WAIT, FINISH} state_t;

    function automatic dcache_pkg::word_t merge_word(
        input dcache_pkg::word_t   old_w,
        input dcache_pkg::word_t   new_w,
        input dcache_pkg::byteen_t be
    );
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < dcache_pkg::BYTES_PER_WORD; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    state_t state;
    logic [dcache_pkg::INDEX_WIDTH:0] sweep_cnt;

    // Stage two request
    logic                               s2_read;
    logic                               s2_write;
    logic                               s2_valid;
    logic [dcache_pkg::ADDR_WIDTH-1:0]  s2_addr;
    dcache_pkg::word_t                  s2_wdata;
    dcache_pkg::byteen_t                s2_byteen;
    logic [dcache_pkg::TAG_WIDTH-1:0]   s2_tag;
    dcache_pkg::index_t                 s2_index;
    logic [dcache_pkg::OFFSET_WIDTH-1:0] s2_offset;

    dcache_pkg::tag_entry_t tag_rd [dcache_pkg::NUM_WAYS];
    dcache_pkg::line_t      line_rd [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::NUM_WAYS-1:0] tag_we;
    logic [dcache_pkg::NUM_WAYS-1:0] line_we;
    dcache_pkg::tag_entry_t tag_wd;
    dcache_pkg::line_t      line_wd;
    dcache_pkg::line_t      base_line;
    dcache_pkg::index_t     rd_index;
    dcache_pkg::index_t     wr_index;
    dcache_pkg::line_t      fill_q;

    logic             hit_any;
    logic             free_any;
    logic             do_write;
    logic             victim_dirty;
    dcache_pkg::way_t hit_way;
    dcache_pkg::way_t free_way;
    dcache_pkg::way_t victim_q;
    dcache_pkg::way_t rr_way;
    dcache_pkg::way_t wr_way;

    assign s2_valid = s2_read || s2_write;
    assign s2_tag = s2_addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
    assign s2_index = s2_addr[IDX_LSB +: dcache_pkg::INDEX_WIDTH];
    assign s2_offset = s2_addr[dcache_pkg::BYTE_OFFSET_WIDTH +: dcache_pkg::OFFSET_WIDTH];

    // Stalled: keep re-reading the held set
    assign rd_index = cpu_stall ? s2_index : cpu_addr[IDX_LSB +: dcache_pkg::INDEX_WIDTH];

    // Tag compare, lowest invalid way found by scanning downwards
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        free_any = 1'b0;
        free_way = '0;
        for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (tag_rd[w].valid && tag_rd[w].tag == s2_tag) begin
                hit_any = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
            if (!tag_rd[w].valid) begin
                free_any = 1'b1;
                free_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign cpu_stall = (state != IDLE) || (s2_valid && !hit_any);

    // Write hit in stage two, or the refilled line in FINISH
    assign do_write = (state == FINISH) || (state == IDLE && s2_write && hit_any);
    assign wr_way = (state == FINISH) ? victim_q : hit_way;
    assign wr_index = (state == SWEEP) ? sweep_cnt[dcache_pkg::INDEX_WIDTH-1:0] : s2_index;
    assign base_line = (state == FINISH) ? fill_q : line_rd[hit_way];

    always_comb begin
        line_wd = base_line;
        if (s2_write) begin
            line_wd[s2_offset] = merge_word(base_line[s2_offset], s2_wdata, s2_byteen);
        end
        tag_wd = '0;
        if (state != SWEEP) begin
            tag_wd = '{valid: 1'b1, dirty: s2_write, tag: s2_tag};
        end
    end

    assign victim_dirty = tag_rd[victim_q].valid && tag_rd[victim_q].dirty;
    assign wb_push = (state == PUSH) && victim_dirty && !wb_busy;
    assign wb_evict.addr = {tag_rd[victim_q].tag, s2_index};
    assign wb_evict.line = line_rd[victim_q];

    assign refill.start = (state == START);
    assign refill.line_addr = {s2_tag, s2_index};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SWEEP;
            sweep_cnt <= '0;
            victim_q <= '0;
            rr_way <= '0;
            s2_read <= 1'b0;
            s2_write <= 1'b0;
            cpu_rvalid <= 1'b0;
        end else begin
            cpu_rvalid <= s2_read && ((state == IDLE && hit_any) || state == FINISH);
            if (!cpu_stall) begin
                s2_read <= cpu_read;
                s2_write <= cpu_write;
            end else if (state == FINISH) begin
                // Request retires here so it does not replay as a hit
                s2_read <= 1'b0;
                s2_write <= 1'b0;
            end
            case (state)
                SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == dcache_pkg::NUM_SETS) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (s2_valid && !hit_any) begin
                        victim_q <= free_any ? free_way : rr_way;
                        if (!free_any) begin
                            rr_way <= rr_way + 1'b1;
                        end
                        state <= PUSH;
                    end
                end
                PUSH: begin
                    if (!victim_dirty || !wb_busy) begin
                        state <= START;
                    end
                end
                START: state <= WAIT;
                WAIT: begin
                    if (refill.done) begin
                        state <= FINISH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!cpu_stall) begin
            s2_addr <= cpu_addr;
            s2_wdata <= cpu_wdata;
            s2_byteen <= cpu_byteen;
        end
        if (refill.done) begin
            fill_q <= refill.line;
        end
        cpu_rdata <= base_line[s2_offset];
    end

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        assign line_we[w] = do_write && wr_way == dcache_pkg::way_t'(w);
        // Sweep clears every way of a set at once
        assign tag_we[w] = (state == SWEEP) || line_we[w];

        cache_ram #(.entry_t(dcache_pkg::tag_entry_t)) u_tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (wr_index),
            .wdata (tag_wd),
            .raddr (rd_index),
            .rdata (tag_rd[w])
        );

        cache_ram #(.entry_t(dcache_pkg::line_t)) u_line_ram (
            .clk   (clk),
            .we    (line_we[w]),
            .waddr (wr_index),
            .wdata (line_wd),
            .raddr (rd_index),
            .rdata (line_rd[w])
        );
    end

endmodule

`default_nettype wire

/* design/refill_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_engine (
    input  logic      clk,
    input  logic      rst,
    refill_if.engine  ctl,
    mem_bus_if.master bus
);

    localparam int LAST_WORD = dcache_pkg::WORDS_PER_LINE - 1;

    logic                                active;
    logic                                done_q;
    logic [dcache_pkg::OFFSET_WIDTH-1:0] cnt;
    dcache_pkg::line_t                   buffer;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            done_q <= 1'b0;
            cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (ctl.start) begin
                active <= 1'b1;
                cnt <= '0;
            end else if (active && bus.ack) begin
                cnt <= cnt + 1'b1;
                if (cnt == dcache_pkg::OFFSET_WIDTH'(LAST_WORD)) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Line buffer fills one word per ack
    always_ff @(posedge clk) begin
        if (active && bus.ack) begin
            buffer[cnt] <= bus.rdata;
        end
    end

    assign bus.req = active;
    assign bus.we = 1'b0;
    assign bus.addr = {ctl.line_addr, cnt};
    assign bus.wdata = buffer[cnt];
    assign ctl.done = done_q;
    assign ctl.line = buffer;

endmodule

`default_nettype wire

/* design/writeback_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_engine (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  dcache_pkg::evict_t evict,
    output logic               busy,
    mem_bus_if.master          bus
);

    localparam int LAST_WORD = dcache_pkg::WORDS_PER_LINE - 1;

    dcache_pkg::evict_t                  held;
    logic [dcache_pkg::OFFSET_WIDTH-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
        end else if (push && !busy) begin
            busy <= 1'b1;
            cnt <= '0;
        end else if (busy && bus.ack) begin
            cnt <= cnt + 1'b1;
            if (cnt == dcache_pkg::OFFSET_WIDTH'(LAST_WORD)) begin
                busy <= 1'b0;
            end
        end
    end

    // One entry only, the core never pushes while busy
    always_ff @(posedge clk) begin
        if (push && !busy) begin
            held <= evict;
        end
    end

    assign bus.req = busy;
    assign bus.we = 1'b1;
    assign bus.addr = {held.addr, cnt};
    assign bus.wdata = held.line[cnt];

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                                   clk,
    input  logic                                   rst,
    mem_bus_if.slave                               wb,
    mem_bus_if.slave                               rf,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [dcache_pkg::WORD_ADDR_WIDTH-1:0] mem_addr,
    output dcache_pkg::word_t                      mem_wdata,
    input  logic                                   mem_ack,
    input  dcache_pkg::word_t                      mem_rdata
);

    logic rf_owner;
    logic wb_grant;
    logic rf_grant;

    // Write-back wins a free bus, a running refill burst keeps it
    assign wb_grant = wb.req && !(rf_owner && rf.req);
    assign rf_grant = rf.req && !wb_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_owner <= 1'b0;
        end else begin
            rf_owner <= rf_grant;
        end
    end

    assign mem_req = wb.req || rf.req;
    assign mem_we = wb_grant ? wb.we : rf.we;
    assign mem_addr = wb_grant ? wb.addr : rf.addr;
    assign mem_wdata = wb_grant ? wb.wdata : rf.wdata;

    assign wb.ack = mem_ack && wb_grant;
    assign rf.ack = mem_ack && rf_grant;
    assign wb.rdata = mem_rdata;
    assign rf.rdata = mem_rdata;

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cpu_read,
    input  logic                                   cpu_write,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]      cpu_addr,
    input  dcache_pkg::word_t                      cpu_wdata,
    input  dcache_pkg::byteen_t                    cpu_byteen,
    output logic                                   cpu_stall,
    output dcache_pkg::word_t                      cpu_rdata,
    output logic                                   cpu_rvalid,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [dcache_pkg::WORD_ADDR_WIDTH-1:0] mem_addr,
    output dcache_pkg::word_t                      mem_wdata,
    input  logic                                   mem_ack,
    input  dcache_pkg::word_t                      mem_rdata
);

    mem_bus_if wb_bus ();
    mem_bus_if rf_bus ();
    refill_if  refill ();

    logic               wb_push;
    logic               wb_busy;
    dcache_pkg::evict_t wb_evict;

    dcache_core u_core (
        .clk        (clk),
        .rst        (rst),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_byteen (cpu_byteen),
        .cpu_stall  (cpu_stall),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .refill     (refill.core),
        .wb_push    (wb_push),
        .wb_evict   (wb_evict),
        .wb_busy    (wb_busy)
    );

    refill_engine u_refill (
        .clk (clk),
        .rst (rst),
        .ctl (refill.engine),
        .bus (rf_bus.master)
    );

    writeback_engine u_writeback (
        .clk   (clk),
        .rst   (rst),
        .push  (wb_push),
        .evict (wb_evict),
        .busy  (wb_busy),
        .bus   (wb_bus.master)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .wb        (wb_bus.slave),
        .rf        (rf_bus.slave),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* sim/dcache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                                   clk,
    input logic                                   rst,
    input logic                                   cpu_rvalid,
    input logic                                   mem_req,
    input logic                                   mem_we,
    input logic [dcache_pkg::WORD_ADDR_WIDTH-1:0] mem_addr,
    input logic                                   mem_ack
);

    int fail_count = 0;

    rvalid_cleared_by_reset: assert property (@(posedge clk) rst |=> !cpu_rvalid)
        else begin
            fail_count = fail_count + 1;
            $error("cpu_rvalid high in the cycle after reset");
        end

    // Word fields held until the ack for that word
    mem_fields_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> $stable(mem_addr) && $stable(mem_we))
        else begin
            fail_count = fail_count + 1;
            $error("mem_addr or mem_we changed before ack");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst) mem_ack |-> mem_req)
        else begin
            fail_count = fail_count + 1;
            $error("mem_ack seen without mem_req");
        end

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .cpu_rvalid (cpu_rvalid),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack)
);

`default_nettype wire

/* sim/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int CYCLES_PER_OP = 200;

    typedef logic [dcache_pkg::WORD_ADDR_WIDTH-1:0] waddr_t;

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              cpu_read;
    logic                              cpu_write;
    logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr;
    dcache_pkg::word_t                 cpu_wdata;
    dcache_pkg::byteen_t               cpu_byteen;
    logic                              cpu_stall;
    dcache_pkg::word_t                 cpu_rdata;
    logic                              cpu_rvalid;
    logic                              mem_req;
    logic                              mem_we;
    waddr_t                            mem_addr;
    dcache_pkg::word_t                 mem_wdata;
    logic                              mem_ack = 1'b0;
    dcache_pkg::word_t                 mem_rdata = '0;

    // Operations from the golden file
    logic [7:0]                        op_q [$];
    logic [dcache_pkg::ADDR_WIDTH-1:0] addr_q [$];
    dcache_pkg::byteen_t               be_q [$];
    dcache_pkg::word_t                 wdata_q [$];
    dcache_pkg::word_t                 expect_q [$];
    int                                num_ops = 0;
    logic                              ops_loaded = 1'b0;

    // Holds written words only
    // Unwritten words follow the fill pattern
    dcache_pkg::word_t mem_words [waddr_t];
    integer            seed = 32'h7a32;
    int                ack_wait;
    dcache_pkg::word_t next_expected;

    dcache_top dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_byteen (cpu_byteen),
        .cpu_stall  (cpu_stall),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    always #20 clk = ~clk;

    function automatic dcache_pkg::word_t mem_read(input waddr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return dcache_pkg::word_t'(a) ^ 32'h5a5a0000;
    endfunction

    task automatic check_value(input string name, input dcache_pkg::word_t expected,
                               input dcache_pkg::word_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic send_request(input logic [7:0] op, input logic [31:0] addr,
                                input dcache_pkg::byteen_t be, input dcache_pkg::word_t wdata);
        cpu_read = (op == "R");
        cpu_write = (op == "W");
        cpu_addr = addr;
        cpu_byteen = be;
        cpu_wdata = wdata;
        // Held until a rising edge with stall low takes it
        while (cpu_stall) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // Memory model acks each word after zero to three idle cycles
    always @(negedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            ack_wait <= 0;
        end else if (mem_req && ack_wait == 0) begin
            mem_ack <= 1'b1;
            ack_wait <= $unsigned($random(seed)) % 4;
            if (mem_we) begin
                mem_words[mem_addr] = mem_wdata;
            end else begin
                mem_rdata <= mem_read(mem_addr);
            end
        end else begin
            mem_ack <= 1'b0;
            if (mem_req) begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    // Read responses come back in request order
    always @(negedge clk) begin
        if (!rst && cpu_rvalid) begin
            if (expect_q.size() == 0) begin
                $display("read data returned while no read was outstanding");
                $display("Testbench failed");
                $fatal(1, "unexpected read response");
            end else begin
                next_expected = expect_q.pop_front();
                check_value("cpu_rdata", next_expected, cpu_rdata);
            end
        end
    end

    initial begin
        wait (ops_loaded);
        repeat (CYCLES_PER_OP * num_ops) @(posedge clk);
        $display("timeout after %0d cycles with reads still outstanding", CYCLES_PER_OP * num_ops);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int                  fd;
        int                  code;
        string               text;
        logic [7:0]          op;
        logic [31:0]         addr;
        dcache_pkg::byteen_t be;
        dcache_pkg::word_t   wdata;
        dcache_pkg::word_t   expected;

        rst = 1'b1;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_byteen = '0;

        fd = $fopen("sim/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/dcache_golden.txt");
            $display("Testbench failed");
            $fatal(1, "no stimulus file");
        end
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code > 0) begin
                code = $sscanf(text, "%c %h %h %h %h", op, addr, be, wdata, expected);
                if (code == 5 && (op == "R" || op == "W")) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    be_q.push_back(be);
                    wdata_q.push_back(wdata);
                    if (op == "R") begin
                        expect_q.push_back(expected);
                    end
                end
            end
        end
        $fclose(fd);
        num_ops = op_q.size();
        if (num_ops == 0) begin
            $display("the golden file holds no operations");
            $display("Testbench failed");
            $fatal(1, "empty stimulus");
        end
        ops_loaded = 1'b1;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_ops; i++) begin
            send_request(op_q[i], addr_q[i], be_q[i], wdata_q[i]);
        end
        cpu_read = 1'b0;
        cpu_write = 1'b0;

        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (dut.u_assertions.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", dut.u_assertions.fail_count);
            $display("Testbench failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
design/dcache_pkg.sv
design/dcache_ifs.sv
design/cache_ram.sv
design/dcache_core.sv
design/refill_engine.sv
design/writeback_engine.sv
design/mem_arbiter.sv
design/dcache_top.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv

/* Makefile */
TOP = dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* sim/dcache_golden.txt */
// op addr byteen wdata expected
// R checks the returned word against expected, W writes wdata under byteen
R 00000100 0 00000000 5a5a0040
R 00000214 0 00000000 5a5a0085
R 00000108 0 00000000 5a5a0042
R 00000100 0 00000000 5a5a0040
R 00000218 0 00000000 5a5a0086
W 00000104 3 0000beef 00000000
R 00000104 0 00000000 5a5abeef
W 0000010c 8 c3000000 00000000
R 0000010c 0 00000000 c35a0043
W 00000048 f 0badf00d 00000000
R 00000088 0 00000000 5a5a0022
R 00000104 0 00000000 5a5abeef
R 0000010c 0 00000000 c35a0043
R 00000048 0 00000000 0badf00d
W 00000044 1 000000a5 00000000
R 00000044 0 00000000 5a5a00a5
W 00000044 4 00770000 00000000
W 00000108 2 00003c00 00000000
R 00000044 0 00000000 5a7700a5
R 00000108 0 00000000 5a5a3c42
W 00000108 f 12345678 00000000
R 00000108 0 00000000 12345678
R 00000048 0 00000000 0badf00d
R 000000c0 0 00000000 5a5a0030
R 00000100 0 00000000 5a5a0040
R 00000108 0 00000000 12345678
R 0000010c 0 00000000 c35a0043
R 00000044 0 00000000 5a7700a5
W 12345674 f cafef00d 00000000
R 12345674 0 00000000 cafef00d
R 12345670 0 00000000 5ed7159c
